/* common/md_data_pkg.sv */
// Data widths and vector types of the RV32M multiply/divide unit
// Shared by the dispatcher, the MAC multiplier and the long divider

`default_nettype none

package md_data_pkg;

  // Operand width and half-word slice width of the multiplier
  localparam int unsigned XLEN = 32;
  localparam int unsigned HALF = 16;

  // Compare steps of the divider in the COMP state, the last one runs in LAST
  localparam int unsigned DIV_STEPS = 31;

  // Operand or result word
  typedef logic [XLEN-1:0] word_t;

  // Multiplier operand slice
  typedef logic [HALF-1:0] half_t;

  // Accumulator with room for carry and sign
  typedef logic [XLEN+1:0] mac_t;

  // Bit position counter of the divider
  typedef logic [4:0] div_cnt_t;

endpackage

`default_nettype wire

/* common/md_op_pkg.sv */
// Operation encoding and request bundle of the multiply/divide unit
// A request carries the operation, the per-operand sign flags and both operands

`default_nettype none

package md_op_pkg;

  // MULH covers MULH, MULHSU and MULHU through the sign flags
  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  // Sign flags mark the operand as two's complement
  typedef struct packed {
    md_op_e             op;
    logic               sign_a;
    logic               sign_b;
    md_data_pkg::word_t a;
    md_data_pkg::word_t b;
  } md_req_t;

endpackage

`default_nettype wire

/* logic/md_dispatch.sv */
// Operation dispatcher of the multiply/divide unit
// Steers the enable to the multiplier or the divider and merges their results

`timescale 1ns/1ps
`default_nettype none

module md_dispatch (
  input  logic                en_i,
  input  md_op_pkg::md_req_t  req_i,
  output logic                mult_en_o,
  output logic                div_en_o,
  input  md_data_pkg::word_t  mult_result_i,
  input  md_data_pkg::word_t  div_result_i,
  input  logic                mult_valid_i,
  input  logic                div_valid_i,
  output md_data_pkg::word_t  result_o,
  output logic                valid_o
);

  import md_op_pkg::*;

  logic is_div;

  // DIV and REM belong to the divider, MULL and MULH to the multiplier
  assign is_div = (req_i.op == MD_OP_DIV) || (req_i.op == MD_OP_REM);

  assign mult_en_o = en_i & ~is_div;
  assign div_en_o  = en_i & is_div;

  // Only the enabled unit can raise its strobe
  assign valid_o  = mult_valid_i | div_valid_i;
  assign result_o = is_div ? div_result_i : mult_result_i;

endmodule

`default_nettype wire

/* mult/mult_mac.sv */
// Sequential 17x17 multiply-accumulate multiplier
// MULL takes three enabled cycles, MULH four, one half-word product per cycle

`timescale 1ns/1ps
`default_nettype none

module mult_mac (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_op_pkg::md_req_t  req_i,
  output md_data_pkg::word_t  result_o,
  output logic                valid_o
);

  import md_data_pkg::*;
  import md_op_pkg::*;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  mac_t               mac_q, mac_d;
  mac_t               accum;
  logic signed [XLEN+1:0] mac_res;
  half_t              op_a, op_b;
  logic               ext_a, ext_b;
  logic               sign_a, sign_b;
  logic               signed_mult;
  logic               is_mull;
  logic               valid;

  // Effective operand signs
  assign sign_a      = req_i.sign_a & req_i.a[XLEN-1];
  assign sign_b      = req_i.sign_b & req_i.b[XLEN-1];
  assign signed_mult = req_i.sign_a | req_i.sign_b;
  assign is_mull     = (req_i.op == MD_OP_MULL);

  // Single 17x17 signed multiplier with accumulate
  assign mac_res = $signed({ext_a, op_a}) * $signed({ext_b, op_b}) + $signed(accum);

  always_comb begin
    op_a    = req_i.a[HALF-1:0];
    op_b    = req_i.b[HALF-1:0];
    ext_a   = 1'b0;
    ext_b   = 1'b0;
    accum   = '0;
    mac_d   = $unsigned(mac_res);
    state_d = state_q;
    valid   = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, always unsigned
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh plus the upper half of al*bl
        op_b  = req_i.b[XLEN-1:HALF];
        ext_b = sign_b;
        accum = {{(HALF+2){1'b0}}, mac_q[XLEN-1:HALF]};
        if (is_mull) begin
          // Keep the finished low half of the product in place
          mac_d = {2'b00, mac_res[HALF-1:0], mac_q[HALF-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        op_a  = req_i.a[XLEN-1:HALF];
        ext_a = sign_a;
        if (is_mull) begin
          accum   = {{(HALF+2){1'b0}}, mac_q[XLEN-1:HALF]};
          mac_d   = {2'b00, mac_res[HALF-1:0], mac_q[HALF-1:0]};
          valid   = 1'b1;
          state_d = ALBL;
        end else begin
          accum   = mac_q;
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh plus the partial sum shifted down by a half word
        op_a    = req_i.a[XLEN-1:HALF];
        op_b    = req_i.b[XLEN-1:HALF];
        ext_a   = sign_a;
        ext_b   = sign_b;
        accum   = {{HALF{signed_mult & mac_q[XLEN+1]}}, mac_q[XLEN+1:HALF]};
        valid   = 1'b1;
        state_d = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      mac_q   <= '0;
    end else if (en_i) begin
      state_q <= state_d;
      mac_q   <= mac_d;
    end
  end

  // Low word of the MAC output is the result in the final state
  assign result_o = mac_d[XLEN-1:0];
  assign valid_o  = en_i & valid;

endmodule

`default_nettype wire

/* div/div_long.sv */
// Long-division divider for DIV and REM, signed and unsigned
// Works on absolute values one quotient bit per cycle, then fixes the sign

`timescale 1ns/1ps
`default_nettype none

module div_long (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_op_pkg::md_req_t  req_i,
  output md_data_pkg::word_t  result_o,
  output logic                valid_o
);

  import md_data_pkg::*;
  import md_op_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e state_q, state_d;

  word_t      rem_q, rem_d;
  word_t      num_q, num_d;
  word_t      den_q, den_d;
  word_t      quo_q, quo_d;
  div_cnt_t   cnt_q, cnt_d;
  logic       dbz_q, dbz_d;

  word_t      add_a, add_b;
  logic [XLEN:0] add_res;
  logic       is_div;
  logic       div_sign_a, div_sign_b;
  logic       div_change_sign, rem_change_sign;
  logic       is_greater_equal;
  word_t      shifted_rem;
  word_t      next_rem;
  word_t      next_quo;

  assign is_div     = (req_i.op == MD_OP_DIV);
  assign div_sign_a = req_i.sign_a & req_i.a[XLEN-1];
  assign div_sign_b = req_i.sign_b & req_i.b[XLEN-1];

  assign div_change_sign = (div_sign_a ^ div_sign_b) & ~dbz_q;
  assign rem_change_sign = div_sign_a;

  // Shared 33-bit subtractor, bit XLEN is the borrow
  assign add_res = {1'b0, add_a} - {1'b0, add_b};

  // Partial remainder with the next numerator bit shifted in
  // The bit that drops out of rem_q is bit 32 of the partial remainder
  assign shifted_rem      = {rem_q[XLEN-2:0], num_q[cnt_q]};
  assign is_greater_equal = rem_q[XLEN-1] | ~add_res[XLEN];
  assign next_rem         = is_greater_equal ? add_res[XLEN-1:0] : shifted_rem;
  assign next_quo         = quo_q | (word_t'(is_greater_equal) << cnt_q);

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;
    num_d   = num_q;
    den_d   = den_q;
    quo_d   = quo_q;
    cnt_d   = cnt_q;
    dbz_d   = dbz_q;
    add_a   = '0;
    add_b   = req_i.b;

    unique case (state_q)
      IDLE: begin
        dbz_d = (req_i.b == '0);
        // Results for a zero divisor are all ones for DIV and a for REM
        rem_d   = is_div ? '1 : req_i.a;
        state_d = (req_i.b == '0) ? FINISH : ABS_A;
      end

      ABS_A: begin
        // |a| = 0 - a
        add_b   = req_i.a;
        num_d   = div_sign_a ? add_res[XLEN-1:0] : req_i.a;
        quo_d   = '0;
        state_d = ABS_B;
      end

      ABS_B: begin
        // |b| = 0 - b
        add_b   = req_i.b;
        den_d   = div_sign_b ? add_res[XLEN-1:0] : req_i.b;
        rem_d   = '0;
        cnt_d   = div_cnt_t'(DIV_STEPS);
        state_d = COMP;
      end

      COMP: begin
        add_a   = shifted_rem;
        add_b   = den_q;
        rem_d   = next_rem;
        quo_d   = next_quo;
        cnt_d   = cnt_q - 1'b1;
        state_d = (cnt_q == div_cnt_t'(1)) ? LAST : COMP;
      end

      LAST: begin
        // Bit 0 step, keep only the value the operation returns
        add_a   = shifted_rem;
        add_b   = den_q;
        rem_d   = is_div ? next_quo : next_rem;
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        add_b = rem_q;
        if (is_div) begin
          rem_d = div_change_sign ? add_res[XLEN-1:0] : rem_q;
        end else begin
          rem_d = rem_change_sign ? add_res[XLEN-1:0] : rem_q;
        end
        state_d = FINISH;
      end

      FINISH: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rem_q   <= '0;
      num_q   <= '0;
      den_q   <= '0;
      quo_q   <= '0;
      cnt_q   <= '0;
      dbz_q   <= 1'b0;
    end else if (en_i) begin
      state_q <= state_d;
      rem_q   <= rem_d;
      num_q   <= num_d;
      den_q   <= den_d;
      quo_q   <= quo_d;
      cnt_q   <= cnt_d;
      dbz_q   <= dbz_d;
    end
  end

  // rem_q holds the final quotient or remainder in FINISH
  assign result_o = rem_q;
  assign valid_o  = en_i & (state_q == FINISH);

endmodule

`default_nettype wire

/* logic/md_unit_top.sv */
// RV32M multiply/divide unit top level
// Connects the dispatcher to the MAC multiplier and the long divider

`timescale 1ns/1ps
`default_nettype none

module md_unit_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_op_pkg::md_req_t  req_i,
  output md_data_pkg::word_t  result_o,
  output logic                valid_o
);

  import md_data_pkg::*;

  logic  mult_en;
  logic  div_en;
  word_t mult_result;
  word_t div_result;
  logic  mult_valid;
  logic  div_valid;

  md_dispatch i_md_dispatch (
    .en_i          (en_i),
    .req_i         (req_i),
    .mult_en_o     (mult_en),
    .div_en_o      (div_en),
    .mult_result_i (mult_result),
    .div_result_i  (div_result),
    .mult_valid_i  (mult_valid),
    .div_valid_i   (div_valid),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  mult_mac i_mult_mac (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (mult_en),
    .req_i    (req_i),
    .result_o (mult_result),
    .valid_o  (mult_valid)
  );

  div_long i_div_long (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (div_en),
    .req_i    (req_i),
    .result_o (div_result),
    .valid_o  (div_valid)
  );

endmodule

`default_nettype wire

/* test/md_unit_properties.sv */
// Handshake checks on the multiply/divide unit ports
// Attached to the unit top level by bind

`timescale 1ns/1ps
`default_nettype none

module md_unit_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic en_i,
  input logic valid_o
);

  // No strobe while reset is applied or in the first cycle after it
  a_valid_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
    else $error("valid_o high during reset");

  a_valid_low_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_o)
    else $error("valid_o high right after reset");

  a_valid_known: assert property (@(posedge clk_i) !$isunknown(valid_o))
    else $error("valid_o is unknown");

  // The strobe lasts exactly one cycle
  a_valid_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o)
    else $error("valid_o high in two consecutive cycles");

  a_valid_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> en_i)
    else $error("valid_o high while en_i is low");

endmodule

bind md_unit_top md_unit_properties i_md_unit_properties (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .en_i    (en_i),
  .valid_o (valid_o)
);

`default_nettype wire

/* test/tb_md_unit.sv */
// Testbench for the RV32M multiply/divide unit
// Random operands from a fixed seed, checked against a 64-bit reference model

`timescale 1ns/1ps
`default_nettype none

module tb_md_unit;

  import md_data_pkg::*;
  import md_op_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int MAX_LAT    = 40;
  // MULL, MULH, DIV/REM, special cases, pause and back-to-back
  localparam int NUM_OPS    = 200 + 108 + 200 + 6 + 40;

  logic    clk;
  logic    rst_n;
  logic    en;
  md_req_t req;
  word_t   result;
  logic    valid;

  integer seed;
  int     errors;
  int     checks;

  md_unit_top i_md_unit_top (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .en_i     (en),
    .req_i    (req),
    .result_o (result),
    .valid_o  (valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Twice the longest latency per operation leaves room for the pauses
  initial begin
    #((NUM_OPS * MAX_LAT * 2 + 1000) * CLK_PERIOD);
    $display("Watchdog expired, the unit stopped answering");
    $display(">>> FAIL");
    $finish;
  end

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    return 1'($random(seed));
  endfunction

  function automatic md_req_t make_req(input md_op_e op, input logic sa, input logic sb,
                                       input word_t a, input word_t b);
    md_req_t r;
    r.op     = op;
    r.sign_a = sa;
    r.sign_b = sb;
    r.a      = a;
    r.b      = b;
    return r;
  endfunction

  // RISC-V results from 64-bit arithmetic on the extended operands
  function automatic word_t ref_result(input md_req_t r);
    logic [63:0] pa;
    logic [63:0] pb;
    logic [63:0] prod;
    longint      sa;
    longint      sb;
    pa   = r.sign_a ? {{32{r.a[31]}}, r.a} : {32'h0, r.a};
    pb   = r.sign_b ? {{32{r.b[31]}}, r.b} : {32'h0, r.b};
    prod = pa * pb;
    sa   = $signed(pa);
    sb   = $signed(pb);
    if (r.op == MD_OP_MULL) return prod[31:0];
    if (r.op == MD_OP_MULH) return prod[63:32];
    if (r.b == 32'h0) return (r.op == MD_OP_DIV) ? 32'hffff_ffff : r.a;
    // Signed overflow
    if (r.sign_a && r.sign_b && r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      return (r.op == MD_OP_DIV) ? 32'h8000_0000 : 32'h0;
    end
    // Division truncates toward zero and the remainder follows the dividend
    if (r.op == MD_OP_DIV) return word_t'(sa / sb);
    return word_t'(sa % sb);
  endfunction

  // Enabled cycles up to and including the valid cycle
  function automatic int ref_latency(input md_req_t r);
    if (r.op == MD_OP_MULL) return 3;
    if (r.op == MD_OP_MULH) return 4;
    return (r.b == 32'h0) ? 2 : 37;
  endfunction

  task automatic check_val(input string name, input word_t exp_val, input word_t act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
    end
  endtask

  // Runs one operation, optionally with random en gaps, and keeps en high when chained
  task automatic do_op(input string name, input md_req_t r, input bit pause, input bit chain);
    int    n;
    int    stretch;
    bit    done;
    bit    lost;
    word_t got;
    n    = 0;
    done = 1'b0;
    lost = 1'b0;
    got  = '0;
    @(negedge clk);
    req = r;
    en  = 1'b1;
    while (!done) begin
      #1;
      n++;
      if (valid) begin
        got  = result;
        done = 1'b1;
      end else if (n > MAX_LAT) begin
        errors++;
        $display("%s: valid_o did not arrive within %0d enabled cycles", name, MAX_LAT);
        lost = 1'b1;
        done = 1'b1;
      end else begin
        @(negedge clk);
        if (pause && ($unsigned($random(seed)) % 3 == 0)) begin
          en      = 1'b0;
          stretch = 1 + int'($unsigned($random(seed)) % 4);
          repeat (stretch) @(negedge clk);
          en = 1'b1;
        end
      end
    end
    if (!lost) begin
      check_val({name, " result"}, ref_result(r), got);
      check_val({name, " latency"}, word_t'(ref_latency(r)), word_t'(n));
    end
    if (!chain) begin
      @(negedge clk);
      en = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input int n_ops, input int err_before);
    $display("%s: %0d operations, %0d errors", name, n_ops, errors - err_before);
  endtask

  initial begin
    word_t  edge_val [4];
    word_t  a;
    word_t  b;
    logic   sa;
    logic   sb;
    md_op_e op;
    int     e0;
    seed     = 12;
    clk      = 1'b0;
    rst_n    = 1'b0;
    en       = 1'b0;
    req      = '0;
    errors   = 0;
    checks   = 0;
    edge_val = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};
    // The enable is already high in the second reset cycle and at the release edge
    @(negedge clk);
    en = 1'b1;
    fork
      begin
        @(negedge clk);
        rst_n = 1'b1;
      end
    join_none

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      do_op("mull", make_req(MD_OP_MULL, rand_bit(), rand_bit(), rand_word(), rand_word()),
            1'b0, 1'b0);
    end
    report_test("mull", 200, e0);

    // MULH, MULHSU and MULHU
    e0 = errors;
    for (int s = 0; s < 3; s++) begin
      sa = (s < 2);
      sb = (s == 0);
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          do_op("mulh edge", make_req(MD_OP_MULH, sa, sb, edge_val[i], edge_val[j]),
                1'b0, 1'b0);
        end
      end
      for (int i = 0; i < 20; i++) begin
        do_op("mulh", make_req(MD_OP_MULH, sa, sb, rand_word(), rand_word()), 1'b0, 1'b0);
      end
    end
    report_test("mulh", 108, e0);

    e0 = errors;
    for (int i = 0; i < 100; i++) begin
      sa = rand_bit();
      a  = rand_word();
      b  = rand_word();
      // Narrow divisors now and then for large quotients
      if (rand_bit()) begin
        b = b >> ($unsigned($random(seed)) % 32);
      end
      do_op("div", make_req(MD_OP_DIV, sa, sa, a, b), 1'b0, 1'b0);
      do_op("rem", make_req(MD_OP_REM, sa, sa, a, b), 1'b0, 1'b0);
    end
    report_test("div/rem", 200, e0);

    e0 = errors;
    a  = rand_word();
    do_op("div by zero", make_req(MD_OP_DIV, 1'b1, 1'b1, a, 32'h0), 1'b0, 1'b0);
    do_op("rem by zero", make_req(MD_OP_REM, 1'b1, 1'b1, a, 32'h0), 1'b0, 1'b0);
    do_op("divu by zero", make_req(MD_OP_DIV, 1'b0, 1'b0, a, 32'h0), 1'b0, 1'b0);
    do_op("remu by zero", make_req(MD_OP_REM, 1'b0, 1'b0, a, 32'h0), 1'b0, 1'b0);
    do_op("div overflow", make_req(MD_OP_DIV, 1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff),
          1'b0, 1'b0);
    do_op("rem overflow", make_req(MD_OP_REM, 1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff),
          1'b0, 1'b0);
    report_test("special cases", 6, e0);

    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      op = md_op_e'(2'($random(seed)));
      sa = rand_bit();
      do_op("pause", make_req(op, sa, sa, rand_word(), rand_word()), 1'b1, 1'b0);
    end
    report_test("pause", 20, e0);

    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      op = md_op_e'(2'($random(seed)));
      sa = rand_bit();
      do_op("back to back", make_req(op, sa, sa, rand_word(), rand_word()), 1'b0, i < 19);
    end
    report_test("back to back", 20, e0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* md_unit_top.f */
common/md_data_pkg.sv
common/md_op_pkg.sv
logic/md_dispatch.sv
mult/mult_mac.sv
div/div_long.sv
logic/md_unit_top.sv
test/md_unit_properties.sv
test/tb_md_unit.sv

/* run.sh */
#!/bin/sh
# Compile and run the multiply/divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_md_unit \
  -f md_unit_top.f -o tb_md_unit || exit 1
./obj_dir/tb_md_unit > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
